// File: common/corr_cfg_pkg.sv
package corr_cfg_pkg;

   // ----------------------------------------------------------------------
   // Array sizes and widths
   // ----------------------------------------------------------------------
   localparam int N_ANT         = 8;                  // Antennas
   localparam int N_PAIRS       = N_ANT*(N_ANT-1)/2;  // All baselines, 28
   localparam int PAIRS_PER_BLK = N_PAIRS/2;          // Two blocks side by side
   localparam int ACC_W         = 16;                 // Accumulator and bus data
   localparam int ADR_W         = 6;                  // Block, pair and Re/Im bits
   localparam int SUMS_W        = 16;                 // Frame length input

   // ----------------------------------------------------------------------
   // Pair numbering (0,1) (0,2) .. (0,7) (1,2) .. (6,7)
   // ----------------------------------------------------------------------
   function automatic int pair_code(input int k);
      int idx;
      int code;
      idx  = 0;
      code = 0;
      for (int a = 0; a < N_ANT; a++) begin
         for (int b = a + 1; b < N_ANT; b++) begin
            if (idx == k) code = a*N_ANT + b;    // Both antennas in one number
            idx++;
         end
      end
      return code;
   endfunction

   function automatic int pair_ant_a(input int k);
      return pair_code(k) / N_ANT;                 // Lower antenna
   endfunction

   function automatic int pair_ant_b(input int k);
      return pair_code(k) % N_ANT;                 // Upper antenna
   endfunction

endpackage

// File: common/corr_types_pkg.sv
package corr_types_pkg;

   // Antenna sample after the quadrature estimate
   typedef struct packed {
      logic [corr_cfg_pkg::N_ANT-1:0] re;   // Sign bits as sampled
      logic [corr_cfg_pkg::N_ANT-1:0] im;   // Previous accepted sample
   } sample_t;

   // Framing flags that travel with each sample
   typedef struct packed {
      logic valid;                          // Sample present this cycle
      logic first;                          // Overwrite the active bank
      logic last;                           // Frame closes on this sample
   } frame_ctrl_t;

   // ----------------------------------------------------------------------
   // Wishbone classic read bus
   // ----------------------------------------------------------------------
   typedef struct packed {
      logic                           cyc;
      logic                           stb;
      logic                           we;   // Acked, no effect
      logic [corr_cfg_pkg::ADR_W-1:0] adr;
   } bus_req_t;

   typedef struct packed {
      logic                           ack;  // One cycle per request
      logic [corr_cfg_pkg::ACC_W-1:0] dat;
   } bus_rsp_t;

endpackage

// File: design/fake_hilbert.sv
`timescale 1ns/1ps

module fake_hilbert #(
   parameter int N_ANT = corr_cfg_pkg::N_ANT   // Antenna count
) (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic [N_ANT-1:0]        data_i,     // One bit per antenna
   input  logic                    valid_i,
   output corr_types_pkg::sample_t sample_o,
   output logic                    valid_o
);

   logic [N_ANT-1:0] re_q;                     // Latest accepted sample
   logic [N_ANT-1:0] im_q;                     // The one before it
   logic             valid_q;

   // ----------------------------------------------------------------------
   // Delay-line quadrature estimate
   // ----------------------------------------------------------------------
   // A quarter-period delay of a sign-sampled signal is close to one
   // sample at the usual sampling rate, so the previous real bit stands
   // in for the imaginary part
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         re_q    <= '0;                        // Previous sample reads 0
         im_q    <= '0;
         valid_q <= 1'b0;
      end else begin
         valid_q <= valid_i;                   // One cycle through
         if (valid_i) begin
            im_q <= re_q;                      // Older sample shifts down
            re_q <= data_i;
         end
      end
   end

   assign sample_o.re = re_q;
   assign sample_o.im = im_q;
   assign valid_o     = valid_q;

endmodule

// File: design/bank_switch.sv
`timescale 1ns/1ps

module bank_switch (
   input  logic                            clk_i,
   input  logic                            rst_n_i,
   input  corr_types_pkg::sample_t         sample_i,
   input  logic                            valid_i,
   input  logic [corr_cfg_pkg::SUMS_W-1:0] sums_i,    // Samples per frame
   output corr_types_pkg::sample_t         sample_o,
   output corr_types_pkg::frame_ctrl_t     ctrl_o,
   output logic                            swap_o,    // Frame just closed
   output logic                            bank_o     // Bank being written
);

   logic [corr_cfg_pkg::SUMS_W-1:0] rem_q;            // Samples left in frame
   logic                            first;
   logic                            last;
   logic                            swap_q;
   logic                            bank_q;

   // ----------------------------------------------------------------------
   // Frame flags
   // ----------------------------------------------------------------------
   assign first = (rem_q == '0);                      // Nothing left means new frame
   assign last  = first ? (sums_i == corr_cfg_pkg::SUMS_W'(1))
                        : (rem_q == corr_cfg_pkg::SUMS_W'(1));

   assign ctrl_o.valid = valid_i;
   assign ctrl_o.first = first;
   assign ctrl_o.last  = last;
   assign sample_o     = sample_i;                    // Same cycle as the flags

   // ----------------------------------------------------------------------
   // Sample counter and bank flip
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rem_q  <= '0;
         swap_q <= 1'b0;
         bank_q <= 1'b0;
      end else begin
         swap_q <= valid_i && last;                   // Single-cycle strobe
         if (valid_i) begin
            rem_q <= first ? sums_i - 1'b1 : rem_q - 1'b1;  // Length latched here
            if (last) bank_q <= ~bank_q;              // Last sample went to old bank
         end
      end
   end

   assign swap_o = swap_q;
   assign bank_o = bank_q;

endmodule

// File: correlator/correlator_block.sv
`timescale 1ns/1ps

module correlator_block #(
   parameter int PAIR_BASE = 0,                     // First pair held here
   parameter int ACC_W     = corr_cfg_pkg::ACC_W    // Count width
) (
   input  logic                                         clk_i,
   input  logic                                         rst_n_i,
   input  corr_types_pkg::sample_t                      sample_i,
   input  corr_types_pkg::frame_ctrl_t                  ctrl_i,
   input  logic                                         bank_i,   // Write bank
   output logic [corr_cfg_pkg::PAIRS_PER_BLK*ACC_W-1:0] vis_re_o, // Completed bank
   output logic [corr_cfg_pkg::PAIRS_PER_BLK*ACC_W-1:0] vis_im_o
);

   localparam int NP = corr_cfg_pkg::PAIRS_PER_BLK;

   // ----------------------------------------------------------------------
   // One pair of accumulators per baseline
   // ----------------------------------------------------------------------
   // All pairs update in parallel, so a sample lands in every count on
   // the edge after it shows up at the input
   for (genvar p = 0; p < NP; p++) begin : g_pair

      localparam int ANT_A = corr_cfg_pkg::pair_ant_a(PAIR_BASE + p);
      localparam int ANT_B = corr_cfg_pkg::pair_ant_b(PAIR_BASE + p);

      logic                  hit_re;                // re_a == re_b
      logic                  hit_im;                // re_a == im_b
      logic [ACC_W-1:0]      inc_re;
      logic [ACC_W-1:0]      inc_im;
      logic [1:0][ACC_W-1:0] acc_re_q;              // Ping-pong banks
      logic [1:0][ACC_W-1:0] acc_im_q;

      // XNOR of sign bits is the one-bit product
      assign hit_re = (sample_i.re[ANT_A] == sample_i.re[ANT_B]);
      assign hit_im = (sample_i.re[ANT_A] == sample_i.im[ANT_B]);

      assign inc_re = {{(ACC_W-1){1'b0}}, hit_re};  // Zero-extended increments
      assign inc_im = {{(ACC_W-1){1'b0}}, hit_im};

      always_ff @(posedge clk_i or negedge rst_n_i) begin
         if (!rst_n_i) begin
            acc_re_q <= '0;
            acc_im_q <= '0;
         end else if (ctrl_i.valid) begin
            if (ctrl_i.first) begin
               acc_re_q[bank_i] <= inc_re;          // Start of frame clears
               acc_im_q[bank_i] <= inc_im;
            end else begin
               acc_re_q[bank_i] <= acc_re_q[bank_i] + inc_re;
               acc_im_q[bank_i] <= acc_im_q[bank_i] + inc_im;
            end
         end
      end

      // Read side always sees the bank that is at rest
      assign vis_re_o[p*ACC_W +: ACC_W] = acc_re_q[~bank_i];
      assign vis_im_o[p*ACC_W +: ACC_W] = acc_im_q[~bank_i];

   end

endmodule

// File: design/visibility_readback.sv
`timescale 1ns/1ps

module visibility_readback #(
   parameter int ACC_W = corr_cfg_pkg::ACC_W              // Count and data width
) (
   input  logic                                         clk_i,
   input  logic                                         rst_n_i,
   input  corr_types_pkg::bus_req_t                     req_i,
   output corr_types_pkg::bus_rsp_t                     rsp_o,
   input  logic [corr_cfg_pkg::PAIRS_PER_BLK*ACC_W-1:0] blk0_re_i,
   input  logic [corr_cfg_pkg::PAIRS_PER_BLK*ACC_W-1:0] blk0_im_i,
   input  logic [corr_cfg_pkg::PAIRS_PER_BLK*ACC_W-1:0] blk1_re_i,
   input  logic [corr_cfg_pkg::PAIRS_PER_BLK*ACC_W-1:0] blk1_im_i
);

   localparam int NP    = corr_cfg_pkg::PAIRS_PER_BLK;
   localparam int BLK_B = corr_cfg_pkg::ADR_W - 1;        // Block select bit

   logic                        req;
   logic                        sel_blk;
   logic                        sel_im;
   logic [3:0]                  pair_idx;
   logic [NP*ACC_W-1:0]         src;
   logic [ACC_W-1:0]            sel_dat;
   logic                        ack_q;
   logic [ACC_W-1:0]            dat_q;

   // ----------------------------------------------------------------------
   // Address decode and read mux
   // ----------------------------------------------------------------------
   // Request held over into the ack cycle is the one just served
   assign req      = req_i.cyc && req_i.stb && !ack_q;
   assign sel_blk  = req_i.adr[BLK_B];
   assign pair_idx = req_i.adr[4:1];                      // Pair within block
   assign sel_im   = req_i.adr[0];                        // 0 is real

   always_comb begin
      case ({sel_blk, sel_im})
         2'b00:   src = blk0_re_i;
         2'b01:   src = blk0_im_i;
         2'b10:   src = blk1_re_i;
         default: src = blk1_im_i;
      endcase
      if (pair_idx < NP) begin
         sel_dat = src[pair_idx*ACC_W +: ACC_W];
      end else begin
         sel_dat = '0;                                    // Unused slots 14 and 15
      end
   end

   // ----------------------------------------------------------------------
   // Response register
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req;                                    // Exactly one cycle
      end
   end

   always_ff @(posedge clk_i) begin
      if (req) begin
         dat_q <= req_i.we ? '0 : sel_dat;                // Writes return nothing
      end
   end

   assign rsp_o.ack = ack_q;
   assign rsp_o.dat = dat_q;

endmodule

// File: design/tart_correlator.sv
`timescale 1ns/1ps

module tart_correlator #(
   parameter int N_ANT = corr_cfg_pkg::N_ANT,        // Antenna inputs
   parameter int ACC_W = corr_cfg_pkg::ACC_W         // Visibility width
) (
   input  logic                            clk_i,
   input  logic                            rst_n_i,
   input  logic [N_ANT-1:0]                data_i,   // Sign bits
   input  logic                            valid_i,
   input  logic [corr_cfg_pkg::SUMS_W-1:0] sums_i,   // Frame length
   input  corr_types_pkg::bus_req_t        req_i,
   output corr_types_pkg::bus_rsp_t        rsp_o,
   output logic                            swap_o,
   output logic                            bank_o
);

   localparam int VIS_W = corr_cfg_pkg::PAIRS_PER_BLK * ACC_W;

   corr_types_pkg::sample_t     hil_sample;          // Front end out
   logic                        hil_valid;
   corr_types_pkg::sample_t     blk_sample;          // Fanned out to both blocks
   corr_types_pkg::frame_ctrl_t blk_ctrl;
   logic [VIS_W-1:0]            vis0_re;
   logic [VIS_W-1:0]            vis0_im;
   logic [VIS_W-1:0]            vis1_re;
   logic [VIS_W-1:0]            vis1_im;

   // ----------------------------------------------------------------------
   // Front end and framing
   // ----------------------------------------------------------------------
   fake_hilbert #(.N_ANT(N_ANT)) i_fake_hilbert (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .data_i  (data_i),
      .valid_i (valid_i),
      .sample_o(hil_sample),
      .valid_o (hil_valid)
   );

   bank_switch i_bank_switch (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .sample_i(hil_sample),
      .valid_i (hil_valid),
      .sums_i  (sums_i),
      .sample_o(blk_sample),
      .ctrl_o  (blk_ctrl),
      .swap_o  (swap_o),
      .bank_o  (bank_o)
   );

   // ----------------------------------------------------------------------
   // Correlators, pairs 0..13 and 14..27
   // ----------------------------------------------------------------------
   correlator_block #(.PAIR_BASE(0), .ACC_W(ACC_W)) i_correlator_block_0 (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .sample_i(blk_sample),
      .ctrl_i  (blk_ctrl),
      .bank_i  (bank_o),
      .vis_re_o(vis0_re),
      .vis_im_o(vis0_im)
   );

   correlator_block #(.PAIR_BASE(corr_cfg_pkg::PAIRS_PER_BLK), .ACC_W(ACC_W))
      i_correlator_block_1 (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .sample_i(blk_sample),
      .ctrl_i  (blk_ctrl),
      .bank_i  (bank_o),
      .vis_re_o(vis1_re),
      .vis_im_o(vis1_im)
   );

   // Bus side
   visibility_readback #(.ACC_W(ACC_W)) i_visibility_readback (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .req_i    (req_i),
      .rsp_o    (rsp_o),
      .blk0_re_i(vis0_re),
      .blk0_im_i(vis0_im),
      .blk1_re_i(vis1_re),
      .blk1_im_i(vis1_im)
   );

endmodule

// File: testbench/visibility_checker.sv
`timescale 1ns/1ps

module visibility_checker (
   input  logic                            clk_i,
   input  logic                            rst_n_i,
   input  logic [corr_cfg_pkg::N_ANT-1:0]  data_i,
   input  logic                            valid_i,
   input  logic [corr_cfg_pkg::SUMS_W-1:0] sums_i,
   input  corr_types_pkg::bus_req_t        req_i,
   input  corr_types_pkg::bus_rsp_t        rsp_i,
   input  logic                            swap_i,
   input  logic                            bank_i,
   output int                              err_cnt_o,   // Failed checks
   output int                              ack_cnt_o,   // Acks seen on the bus
   output int                              swap_cnt_o   // Swap pulses seen
);

   localparam int NP    = corr_cfg_pkg::PAIRS_PER_BLK;
   localparam int ACC_W = corr_cfg_pkg::ACC_W;
   localparam int ADR_W = corr_cfg_pkg::ADR_W;

   logic [corr_cfg_pkg::N_ANT-1:0] samples[$];   // Every accepted sample, in order
   logic                           pend_valid;   // Accepted last edge, framed now
   int                             pend_idx;
   int                             rem;          // Samples left in current frame
   int                             cur_start;
   int                             cur_len;
   int                             done_start;   // Last completed frame
   int                             done_len;
   logic                           have_done;
   logic                           exp_swap;
   logic                           exp_bank;
   logic                           exp_pend;     // Request waiting for its ack
   logic                           exp_we;
   logic [ADR_W-1:0]               exp_adr;
   logic [ACC_W-1:0]               exp_dat;

   // ----------------------------------------------------------------------
   // Reference visibility for one bus address over one frame
   // ----------------------------------------------------------------------
   function automatic logic [ACC_W-1:0] ref_vis(input int adr, input int start,
                                                input int len);
      int                             pair;
      int                             ant_a;
      int                             ant_b;
      int                             cnt;
      logic                           bit_b;
      logic [corr_cfg_pkg::N_ANT-1:0] cur;
      logic [corr_cfg_pkg::N_ANT-1:0] prev;
      pair = (adr >> 1) & 15;                           // Pair within block
      if (pair >= NP) return '0;                        // Empty slots read zero
      pair  = pair + ((adr >> (ADR_W-1)) & 1) * NP;     // Global pair number
      ant_a = corr_cfg_pkg::pair_ant_a(pair);
      ant_b = corr_cfg_pkg::pair_ant_b(pair);
      cnt   = 0;
      for (int i = start; i < start + len; i++) begin
         cur   = samples[i];
         prev  = (i == 0) ? '0 : samples[i-1];          // Quadrature from the sample before
         bit_b = (adr & 1) ? prev[ant_b] : cur[ant_b];
         if (cur[ant_a] == bit_b) cnt++;
      end
      return ACC_W'(cnt);
   endfunction

   // ----------------------------------------------------------------------
   // Compare process
   // ----------------------------------------------------------------------
   always @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         samples.delete();
         pend_valid = 1'b0;
         rem        = 0;
         have_done  = 1'b0;                             // Completed bank holds zeros
         exp_swap   = 1'b0;
         exp_bank   = 1'b0;
         exp_pend   = 1'b0;
         err_cnt_o  = 0;
         ack_cnt_o  = 0;
         swap_cnt_o = 0;
      end else begin
         if (rsp_i.ack) begin
            ack_cnt_o++;
            if (!exp_pend) begin
               $display("Bus slave raised ack with no request outstanding");
               err_cnt_o++;
            end else if (!exp_we && rsp_i.dat !== exp_dat) begin
               $display("Error at %0t: address %0d read %0d, expected %0d",
                        $time, exp_adr, rsp_i.dat, exp_dat);
               err_cnt_o++;
            end
            exp_pend = 1'b0;
         end else if (exp_pend) begin
            $display("Bus slave gave no ack in the cycle after a request to address %0d",
                     exp_adr);
            err_cnt_o++;
            exp_pend = 1'b0;
         end
         if (req_i.cyc && req_i.stb && !rsp_i.ack) begin  // New request this edge
            exp_pend = 1'b1;
            exp_we   = req_i.we;
            exp_adr  = req_i.adr;
            exp_dat  = have_done ? ref_vis(req_i.adr, done_start, done_len) : '0;
         end
         if (swap_i) swap_cnt_o++;
         if (swap_i !== exp_swap) begin
            $display("Error at %0t: swap_o is %b, expected %b", $time, swap_i, exp_swap);
            err_cnt_o++;
         end
         if (bank_i !== exp_bank) begin
            $display("Error at %0t: bank_o is %b, expected %b", $time, bank_i, exp_bank);
            err_cnt_o++;
         end
         exp_swap = 1'b0;
         if (pend_valid) begin                          // Frame length taken here
            if (rem == 0) begin
               cur_start = pend_idx;
               cur_len   = sums_i;
               rem       = sums_i;
            end
            rem--;
            if (rem == 0) begin                         // Frame complete
               done_start = cur_start;
               done_len   = cur_len;
               have_done  = 1'b1;
               exp_swap   = 1'b1;
               exp_bank   = ~exp_bank;
            end
         end
         pend_valid = valid_i;
         if (valid_i) begin
            pend_idx = samples.size();
            samples.push_back(data_i);
         end
      end
   end

endmodule

// File: testbench/tb_tart_correlator.sv
`timescale 1ns/1ps

module tb_tart_correlator;

   localparam int N_ANT        = corr_cfg_pkg::N_ANT;
   localparam int SUMS_W       = corr_cfg_pkg::SUMS_W;
   localparam int ADR_W        = corr_cfg_pkg::ADR_W;
   localparam int N_ADR        = 1 << ADR_W;           // Whole address space
   localparam int CLK_HALF     = 20;                   // 40 ns period
   localparam int RST_CYCLES   = 10;
   localparam int ACK_WAIT     = 8;                    // Cycles before giving up on ack
   localparam int LEN_SINGLE   = 40;
   localparam int LEN_LONG     = 200;                  // Outlasts 64 reads
   localparam int N_BURST      = 6;
   localparam int BURST_SUM    = 23;
   localparam int N_WRITES     = 4;
   localparam int PLAN_SAMPLES = LEN_SINGLE + LEN_LONG + BURST_SUM + 1;
   localparam int PLAN_READS   = 7 * N_ADR + N_WRITES;
   localparam int WD_CYCLES    = (PLAN_SAMPLES + PLAN_READS) * 4 + 200;

   logic                     clk;
   logic                     rst_n;
   logic [N_ANT-1:0]         data;
   logic                     valid;
   logic [SUMS_W-1:0]        sums;
   logic [SUMS_W-1:0]        next_sums;                // Applies one cycle after its sample
   corr_types_pkg::bus_req_t req;
   corr_types_pkg::bus_rsp_t rsp;
   logic                     swap;
   logic                     bank;
   int                       err_cnt;
   int                       ack_cnt;
   int                       swap_cnt;
   int                       tb_err;
   int                       accesses;
   int                       frames_sent;
   int                       burst_len [N_BURST];

   tart_correlator #(.N_ANT(N_ANT), .ACC_W(corr_cfg_pkg::ACC_W)) i_tart_correlator (
      .clk_i  (clk),
      .rst_n_i(rst_n),
      .data_i (data),
      .valid_i(valid),
      .sums_i (sums),
      .req_i  (req),
      .rsp_o  (rsp),
      .swap_o (swap),
      .bank_o (bank)
   );

   visibility_checker i_visibility_checker (
      .clk_i     (clk),
      .rst_n_i   (rst_n),
      .data_i    (data),
      .valid_i   (valid),
      .sums_i    (sums),
      .req_i     (req),
      .rsp_i     (rsp),
      .swap_i    (swap),
      .bank_i    (bank),
      .err_cnt_o (err_cnt),
      .ack_cnt_o (ack_cnt),
      .swap_cnt_o(swap_cnt)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_HALF) clk = ~clk;
   end

   // ----------------------------------------------------------------------
   // Stimulus tasks, all driving on the falling edge
   // ----------------------------------------------------------------------
   task automatic send_frame(input int len);
      for (int i = 0; i < len; i++) begin
         @(negedge clk);
         sums  = next_sums;
         data  = N_ANT'($urandom);
         valid = 1'b1;
         if (i == 0) next_sums = SUMS_W'(len);      // Framing sees it a cycle later
      end
      frames_sent++;
   endtask

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         @(negedge clk);
         sums  = next_sums;
         valid = 1'b0;
         data  = '0;
      end
   endtask

   task automatic bus_access(input int adr, input logic we);
      int waited;
      @(negedge clk);
      req.cyc = 1'b1;
      req.stb = 1'b1;
      req.we  = we;
      req.adr = ADR_W'(adr);
      waited  = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!rsp.ack && waited < ACK_WAIT);
      if (!rsp.ack) begin
         $display("Bus access to address %0d got no ack within %0d cycles", adr, ACK_WAIT);
         tb_err++;
      end else begin
         @(negedge clk);                             // Stb held through the ack cycle
      end
      req      = '0;
      accesses++;
   endtask

   task automatic read_all();
      for (int a = 0; a < N_ADR; a++) bus_access(a, 1'b0);
   endtask

   task automatic report_counts();
      $display("Checks done: %0d acks, %0d swaps, %0d checker errors, %0d bench errors",
               ack_cnt, swap_cnt, err_cnt, tb_err);
   endtask

   // Watchdog sized from the planned traffic
   initial begin
      repeat (WD_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles and the run did not finish", WD_CYCLES);
      report_counts();
      $display("*** FAILED ***");
      $finish;
   end

   // ----------------------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------------------
   initial begin
      void'($urandom(32'he5854e88));
      burst_len   = '{5, 1, 1, 12, 1, 3};
      rst_n       = 1'b0;
      data        = '0;
      valid       = 1'b0;
      sums        = SUMS_W'(LEN_SINGLE);
      next_sums   = SUMS_W'(LEN_SINGLE);
      req         = '0;
      tb_err      = 0;
      accesses    = 0;
      frames_sent = 0;
      repeat (RST_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      idle_cycles(2);
      read_all();                                    // Both banks still zero
      send_frame(LEN_SINGLE);
      idle_cycles(4);
      read_all();
      fork                                           // Reads while a frame fills
         send_frame(LEN_LONG);
         read_all();
      join
      idle_cycles(4);
      read_all();
      for (int f = 0; f < N_BURST; f++) send_frame(burst_len[f]);  // No gaps
      idle_cycles(4);
      read_all();
      send_frame(1);
      idle_cycles(4);
      read_all();
      bus_access(0, 1'b1);                           // Writes only get an ack
      bus_access(5, 1'b1);
      bus_access(33, 1'b1);
      bus_access(63, 1'b1);
      read_all();
      idle_cycles(2);
      if (ack_cnt != accesses) begin
         $display("Checker saw %0d acks for %0d bus accesses", ack_cnt, accesses);
         tb_err++;
      end
      if (swap_cnt != frames_sent) begin
         $display("Counted %0d swap pulses for %0d frames sent", swap_cnt, frames_sent);
         tb_err++;
      end
      report_counts();
      if (err_cnt == 0 && tb_err == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// File: tart_correlator.f
common/corr_cfg_pkg.sv
common/corr_types_pkg.sv
design/fake_hilbert.sv
design/bank_switch.sv
correlator/correlator_block.sv
design/visibility_readback.sv
design/tart_correlator.sv
testbench/visibility_checker.sv
testbench/tb_tart_correlator.sv

// File: Bender.yml
package:
  name: tart_correlator

sources:
  - common/corr_cfg_pkg.sv
  - common/corr_types_pkg.sv
  - design/fake_hilbert.sv
  - design/bank_switch.sv
  - correlator/correlator_block.sv
  - design/visibility_readback.sv
  - design/tart_correlator.sv
  - target: test
    files:
      - testbench/visibility_checker.sv
      - testbench/tb_tart_correlator.sv
